// File: common/mem_subsys_pkg.sv
package mem_subsys_pkg;

  // Bus widths
  localparam int WORD_W = 32;
  localparam int ADDR_W = 32;

  // One data word, always a full 32-bit access
  typedef logic [WORD_W-1:0] word_t;

  // Byte address, low two bits unused by the memory
  typedef logic [ADDR_W-1:0] addr_t;

  // Core port to Wishbone bridge sequencing
  typedef enum logic [1:0] {
    IDLE,      // Request passes straight onto the bus
    WAIT_ACK,  // Bus cycle open, waiting for the arbiter
    RESPOND    // Grant goes back to the core
  } bridge_state_t;

  // Shared memory owner
  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_INSTR,
    ARB_DATA
  } arb_state_t;

endpackage

// File: core_bridge/instr_bridge.sv
`timescale 1ns/100ps

module instr_bridge import mem_subsys_pkg::*; (
  input  logic  clk_core,
  input  logic  reset_i,

  // Core instruction port
  input  logic  req_i,
  input  addr_t addr_i,
  output logic  gnt_o,
  output word_t rdata_o,

  // Read-only Wishbone side
  output logic  wb_cyc_o,
  output logic  wb_stb_o,
  output addr_t wb_addr_o,
  input  logic  wb_ack_i,
  input  word_t wb_rdata_i
);

  bridge_state_t state_q;
  bridge_state_t state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (req_i) begin
          state_d = WAIT_ACK;
        end
      end
      WAIT_ACK: begin
        if (wb_ack_i) begin
          state_d = RESPOND;
        end
      end
      RESPOND: begin
        state_d = IDLE;  // Core sees the grant this cycle
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // Request goes out in the same cycle while idle, held request masked in RESPOND
  assign wb_cyc_o  = (state_q == WAIT_ACK) || ((state_q == IDLE) && req_i);
  assign wb_stb_o  = wb_cyc_o;
  assign wb_addr_o = addr_i;  // Core holds it until the grant

  always_ff @(posedge clk_core) begin
    if (reset_i) begin
      state_q <= IDLE;
      gnt_o   <= 1'b0;
    end else begin
      state_q <= state_d;
      gnt_o   <= wb_ack_i;  // Grant doubles as rvalid on this port
    end
  end

  // Return data, one stage behind the ack
  always_ff @(posedge clk_core) begin
    if (wb_ack_i) begin
      rdata_o <= wb_rdata_i;
    end
  end

  // Fetch address must not move while the bus cycle is open
  addr_held_a : assert property (@(posedge clk_core) disable iff (reset_i)
    state_q == WAIT_ACK |-> $stable(addr_i));

endmodule

// File: core_bridge/data_bridge.sv
`timescale 1ns/100ps

module data_bridge import mem_subsys_pkg::*; (
  input  logic  clk_core,
  input  logic  reset_i,

  // Core data port
  input  logic  req_i,
  input  logic  we_i,
  input  addr_t addr_i,
  input  word_t wdata_i,
  output logic  gnt_o,
  output logic  rvalid_o,
  output word_t rdata_o,

  // Wishbone side
  output logic  wb_cyc_o,
  output logic  wb_stb_o,
  output logic  wb_we_o,
  output addr_t wb_addr_o,
  output word_t wb_wdata_o,
  input  logic  wb_ack_i,
  input  word_t wb_rdata_i
);

  bridge_state_t state_q;
  bridge_state_t state_d;
  logic          we_q;  // Access in flight is a write

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (req_i) begin
          state_d = WAIT_ACK;
        end
      end
      WAIT_ACK: begin
        if (wb_ack_i) begin
          state_d = RESPOND;
        end
      end
      RESPOND: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  assign wb_cyc_o   = (state_q == WAIT_ACK) || ((state_q == IDLE) && req_i);
  assign wb_stb_o   = wb_cyc_o;
  assign wb_we_o    = we_i;
  assign wb_addr_o  = addr_i;
  assign wb_wdata_o = wdata_i;

  always_ff @(posedge clk_core) begin
    if (reset_i) begin
      state_q  <= IDLE;
      we_q     <= 1'b0;
      gnt_o    <= 1'b0;
      rvalid_o <= 1'b0;
    end else begin
      state_q  <= state_d;
      gnt_o    <= wb_ack_i;
      rvalid_o <= wb_ack_i && !we_q;  // Writes get a grant only
      if ((state_q == IDLE) && req_i) begin
        we_q <= we_i;
      end
    end
  end

  always_ff @(posedge clk_core) begin
    if (wb_ack_i) begin
      rdata_o <= wb_rdata_i;
    end
  end

  // Write controls stay put until the grant
  wr_held_a : assert property (@(posedge clk_core) disable iff (reset_i)
    state_q == WAIT_ACK |-> $stable(we_i) && $stable(wdata_i) && $stable(addr_i));

  rvalid_gnt_a : assert property (@(posedge clk_core) disable iff (reset_i)
    $rose(rvalid_o) |-> gnt_o);

endmodule

// File: src/wb_arbiter.sv
`timescale 1ns/100ps

module wb_arbiter import mem_subsys_pkg::*; (
  input  logic  clk_core,
  input  logic  reset_i,

  // Instruction bus, read only
  input  logic  i_cyc_i,
  input  logic  i_stb_i,
  input  addr_t i_addr_i,
  output logic  i_ack_o,
  output word_t i_rdata_o,

  // Data bus
  input  logic  d_cyc_i,
  input  logic  d_stb_i,
  input  logic  d_we_i,
  input  addr_t d_addr_i,
  input  word_t d_wdata_i,
  output logic  d_ack_o,
  output word_t d_rdata_o,

  // Shared memory port
  output logic  mem_en_o,
  output logic  mem_we_o,
  output addr_t mem_addr_o,
  output word_t mem_wdata_o,
  input  word_t mem_rdata_i
);

  arb_state_t state_q;
  logic       prio_data_q;  // Data bus wins the next tie
  logic       i_req;
  logic       d_req;
  logic       pick_data;

  // A bus being acked still shows cyc, so it must not be picked again
  assign i_req = i_cyc_i && i_stb_i && !i_ack_o;
  assign d_req = d_cyc_i && d_stb_i && !d_ack_o;

  assign pick_data = d_req && (!i_req || prio_data_q);

  always_ff @(posedge clk_core) begin
    if (reset_i) begin
      state_q     <= ARB_IDLE;
      prio_data_q <= 1'b0;
      i_ack_o     <= 1'b0;
      d_ack_o     <= 1'b0;
    end else begin
      // Ack trails the memory access by one cycle, with the read data
      i_ack_o <= (state_q == ARB_INSTR);
      d_ack_o <= (state_q == ARB_DATA);
      case (state_q)
        ARB_IDLE: begin
          if (pick_data) begin
            state_q     <= ARB_DATA;
            prio_data_q <= 1'b0;
          end else if (i_req) begin
            state_q     <= ARB_INSTR;
            prio_data_q <= 1'b1;
          end
        end
        ARB_INSTR, ARB_DATA: begin
          state_q <= ARB_IDLE;  // One memory cycle per grant
        end
        default: begin
          state_q <= ARB_IDLE;
        end
      endcase
    end
  end

  // Memory driven from the owner's bus for the single access cycle
  assign mem_en_o    = (state_q != ARB_IDLE);
  assign mem_we_o    = (state_q == ARB_DATA) && d_we_i;
  assign mem_addr_o  = (state_q == ARB_DATA) ? d_addr_i : i_addr_i;
  assign mem_wdata_o = d_wdata_i;

  // Read data steered to the bus being acked
  assign i_rdata_o = i_ack_o ? mem_rdata_i : '0;
  assign d_rdata_o = d_ack_o ? mem_rdata_i : '0;

  one_ack_a : assert property (@(posedge clk_core) disable iff (reset_i)
    !(i_ack_o && d_ack_o));

  // Bridges keep cyc up until they see their ack
  i_ack_cyc_a : assert property (@(posedge clk_core) disable iff (reset_i)
    i_ack_o |-> i_cyc_i);

  d_ack_cyc_a : assert property (@(posedge clk_core) disable iff (reset_i)
    d_ack_o |-> d_cyc_i);

endmodule

// File: src/wb_memory.sv
`timescale 1ns/100ps

module wb_memory import mem_subsys_pkg::*; #(
  parameter int MEM_DEPTH_LOG2 = 10
) (
  input  logic  clk_core,
  input  logic  en_i,
  input  logic  we_i,
  input  addr_t addr_i,
  input  word_t wdata_i,
  output word_t rdata_o
);

  localparam int DEPTH = 1 << MEM_DEPTH_LOG2;

  word_t                     mem [DEPTH];
  logic [MEM_DEPTH_LOG2-1:0] word_idx;

  // Word index, upper address bits ignored so the space wraps
  assign word_idx = addr_i[MEM_DEPTH_LOG2+1:2];

  always_ff @(posedge clk_core) begin
    if (en_i) begin
      if (we_i) begin
        mem[word_idx] <= wdata_i;
      end
      rdata_o <= mem[word_idx];  // Old contents on a write
    end
  end

endmodule

// File: src/mem_subsys_top.sv
`timescale 1ns/100ps

module mem_subsys_top import mem_subsys_pkg::*; #(
  parameter int MEM_DEPTH_LOG2 = 10
) (
  input  logic  clk_core,
  input  logic  reset_i,

  // Instruction port
  input  logic  instr_req_i,
  input  addr_t instr_addr_i,
  output logic  instr_gnt_o,
  output word_t instr_rdata_o,

  // Data port
  input  logic  data_req_i,
  input  logic  data_we_i,
  input  addr_t data_addr_i,
  input  word_t data_wdata_i,
  output logic  data_gnt_o,
  output logic  data_rvalid_o,
  output word_t data_rdata_o
);

  // Instruction bridge bus
  logic  i_cyc;
  logic  i_stb;
  addr_t i_addr;
  logic  i_ack;
  word_t i_rdata;

  // Data bridge bus
  logic  d_cyc;
  logic  d_stb;
  logic  d_we;
  addr_t d_addr;
  word_t d_wdata;
  logic  d_ack;
  word_t d_rdata;

  // Memory port
  logic  mem_en;
  logic  mem_we;
  addr_t mem_addr;
  word_t mem_wdata;
  word_t mem_rdata;

  instr_bridge u_instr_bridge (
    .clk_core   (clk_core),
    .reset_i    (reset_i),
    .req_i      (instr_req_i),
    .addr_i     (instr_addr_i),
    .gnt_o      (instr_gnt_o),
    .rdata_o    (instr_rdata_o),
    .wb_cyc_o   (i_cyc),
    .wb_stb_o   (i_stb),
    .wb_addr_o  (i_addr),
    .wb_ack_i   (i_ack),
    .wb_rdata_i (i_rdata)
  );

  data_bridge u_data_bridge (
    .clk_core   (clk_core),
    .reset_i    (reset_i),
    .req_i      (data_req_i),
    .we_i       (data_we_i),
    .addr_i     (data_addr_i),
    .wdata_i    (data_wdata_i),
    .gnt_o      (data_gnt_o),
    .rvalid_o   (data_rvalid_o),
    .rdata_o    (data_rdata_o),
    .wb_cyc_o   (d_cyc),
    .wb_stb_o   (d_stb),
    .wb_we_o    (d_we),
    .wb_addr_o  (d_addr),
    .wb_wdata_o (d_wdata),
    .wb_ack_i   (d_ack),
    .wb_rdata_i (d_rdata)
  );

  wb_arbiter u_wb_arbiter (
    .clk_core    (clk_core),
    .reset_i     (reset_i),
    .i_cyc_i     (i_cyc),
    .i_stb_i     (i_stb),
    .i_addr_i    (i_addr),
    .i_ack_o     (i_ack),
    .i_rdata_o   (i_rdata),
    .d_cyc_i     (d_cyc),
    .d_stb_i     (d_stb),
    .d_we_i      (d_we),
    .d_addr_i    (d_addr),
    .d_wdata_i   (d_wdata),
    .d_ack_o     (d_ack),
    .d_rdata_o   (d_rdata),
    .mem_en_o    (mem_en),
    .mem_we_o    (mem_we),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .mem_rdata_i (mem_rdata)
  );

  wb_memory #(
    .MEM_DEPTH_LOG2 (MEM_DEPTH_LOG2)
  ) u_wb_memory (
    .clk_core (clk_core),
    .en_i     (mem_en),
    .we_i     (mem_we),
    .addr_i   (mem_addr),
    .wdata_i  (mem_wdata),
    .rdata_o  (mem_rdata)
  );

endmodule

// File: testbench/tb_mem_subsys.sv
`timescale 1ns/100ps

module tb_mem_subsys import mem_subsys_pkg::*; ();

  localparam int DEPTH_LOG2  = 10;
  localparam int GNT_TIMEOUT = 50;
  localparam int N_PAIRS     = 32;
  localparam int N_RANDOM    = 200;

  logic  clk_core;
  logic  reset_i;
  logic  instr_req_i;
  addr_t instr_addr_i;
  logic  instr_gnt_o;
  word_t instr_rdata_o;
  logic  data_req_i;
  logic  data_we_i;
  addr_t data_addr_i;
  word_t data_wdata_i;
  logic  data_gnt_o;
  logic  data_rvalid_o;
  word_t data_rdata_o;

  word_t ref_mem [int unsigned];  // Keyed by word index
  addr_t pair_addr [N_PAIRS];

  // Results waiting for the compare process
  string res_name_q [$];
  int    res_kind_q [$];  // 0 word, 1 flag, 2 cycle count
  word_t res_exp_q [$];
  word_t res_act_q [$];

  int n_tests;
  int n_checks;
  int n_errors;
  int err_base;
  bit timed_out;
  bit stuck;

  mem_subsys_top #(.MEM_DEPTH_LOG2 (DEPTH_LOG2)) uut (
    .clk_core      (clk_core),
    .reset_i       (reset_i),
    .instr_req_i   (instr_req_i),
    .instr_addr_i  (instr_addr_i),
    .instr_gnt_o   (instr_gnt_o),
    .instr_rdata_o (instr_rdata_o),
    .data_req_i    (data_req_i),
    .data_we_i     (data_we_i),
    .data_addr_i   (data_addr_i),
    .data_wdata_i  (data_wdata_i),
    .data_gnt_o    (data_gnt_o),
    .data_rvalid_o (data_rvalid_o),
    .data_rdata_o  (data_rdata_o)
  );

  initial begin
    clk_core = 1'b0;
    forever #10 clk_core = ~clk_core;
  end

  // Upper address bits are dropped, so the word space wraps
  function automatic int unsigned word_index(addr_t addr);
    return (addr >> 2) % (1 << DEPTH_LOG2);
  endfunction

  function automatic addr_t word_addr(int unsigned idx);
    return addr_t'(idx) << 2;
  endfunction

  function automatic word_t ref_read(addr_t addr);
    if (ref_mem.exists(word_index(addr))) begin
      return ref_mem[word_index(addr)];
    end
    return '0;
  endfunction

  function automatic void model_store(addr_t addr, word_t wdata);
    ref_mem[word_index(addr)] = wdata;
  endfunction

  task automatic check_word(input string name, input word_t exp_w, input word_t act_w);
    n_checks++;
    if (act_w !== exp_w) begin
      n_errors++;
      $display("[FAIL] %s: expected %08h, actual %08h", name, exp_w, act_w);
    end
  endtask

  task automatic check_flag(input string name, input bit exp_b, input bit act_b);
    n_checks++;
    if (act_b != exp_b) begin
      n_errors++;
      $display("[FAIL] %s: expected %0b, actual %0b", name, exp_b, act_b);
    end
  endtask

  task automatic check_cycles(input string name, input int exp_n, input int act_n);
    n_checks++;
    if (act_n != exp_n) begin
      n_errors++;
      $display("[FAIL] %s: expected %0d cycles, actual %0d cycles", name, exp_n, act_n);
    end
  endtask

  task automatic queue_result(input string name, input int kind, input word_t exp_w,
                              input word_t act_w);
    res_name_q.push_back(name);
    res_kind_q.push_back(kind);
    res_exp_q.push_back(exp_w);
    res_act_q.push_back(act_w);
  endtask

  always @(posedge clk_core) begin : compare_proc
    string name;
    int    kind;
    word_t exp_w;
    word_t act_w;
    while (res_kind_q.size() > 0) begin
      name  = res_name_q.pop_front();
      kind  = res_kind_q.pop_front();
      exp_w = res_exp_q.pop_front();
      act_w = res_act_q.pop_front();
      case (kind)
        0: check_word(name, exp_w, act_w);
        1: check_flag(name, exp_w[0], act_w[0]);
        default: check_cycles(name, int'(exp_w), int'(act_w));
      endcase
    end
  end

  // Core side of each port, called and returning on a falling edge
  task automatic instr_port(input addr_t addr, output word_t rdata, output int lat);
    int cycles;
    cycles       = 0;
    instr_req_i  = 1'b1;
    instr_addr_i = addr;
    do begin
      @(negedge clk_core);
      cycles++;
    end while (!instr_gnt_o && cycles < GNT_TIMEOUT);
    rdata       = instr_rdata_o;
    lat         = cycles;
    instr_req_i = 1'b0;
    if (!instr_gnt_o) begin
      $display("Instruction port saw no grant within %0d cycles", GNT_TIMEOUT);
      timed_out = 1'b1;
    end
  endtask

  task automatic data_port(input logic we, input addr_t addr, input word_t wdata,
                           output word_t rdata, output logic rvalid, output int lat);
    int cycles;
    cycles       = 0;
    data_req_i   = 1'b1;
    data_we_i    = we;
    data_addr_i  = addr;
    data_wdata_i = wdata;
    do begin
      @(negedge clk_core);
      cycles++;
    end while (!data_gnt_o && cycles < GNT_TIMEOUT);
    rdata      = data_rdata_o;
    rvalid     = data_rvalid_o;
    lat        = cycles;
    data_req_i = 1'b0;
    if (!data_gnt_o) begin
      $display("Data port saw no grant within %0d cycles", GNT_TIMEOUT);
      timed_out = 1'b1;
    end
  endtask

  task automatic instr_fetch(input string name, input addr_t addr, output int lat);
    word_t expected;
    word_t rdata;
    expected = ref_read(addr);
    instr_port(addr, rdata, lat);
    queue_result(name, 0, expected, rdata);
  endtask

  task automatic store_word(input string name, input addr_t addr, input word_t wdata);
    word_t rdata;
    logic  rvalid;
    int    lat;
    data_port(1'b1, addr, wdata, rdata, rvalid, lat);
    model_store(addr, wdata);
    queue_result({name, " rvalid"}, 1, '0, word_t'(rvalid));  // Writes never see rvalid
  endtask

  task automatic load_word(input string name, input addr_t addr, output int lat);
    word_t expected;
    word_t rdata;
    logic  rvalid;
    expected = ref_read(addr);
    data_port(1'b0, addr, '0, rdata, rvalid, lat);
    queue_result(name, 0, expected, rdata);
    queue_result({name, " rvalid"}, 1, word_t'(1'b1), word_t'(rvalid));
  endtask

  task automatic end_test(input string name);
    int waited;
    int errs;
    waited = 0;
    while (res_kind_q.size() > 0 && waited < 10) begin
      @(negedge clk_core);
      waited++;
    end
    if (res_kind_q.size() > 0) begin
      $display("Results of test %s were never compared", name);
      stuck = 1'b1;
    end
    errs     = n_errors - err_base;
    err_base = n_errors;
    n_tests++;
    $display("Test %0d (%s) done with %0d errors", n_tests, name, errs);
  endtask

  initial begin
    wait (timed_out);
    $display("Run stopped after a grant timeout");
    $display("Verification failed");
    $finish;
  end

  initial begin : main_seq
    int          lat;
    int unsigned idx;
    addr_t       addr;
    word_t       wdata;
    reset_i      = 1'b1;
    instr_req_i  = 1'b0;
    instr_addr_i = '0;
    data_req_i   = 1'b0;
    data_we_i    = 1'b0;
    data_addr_i  = '0;
    data_wdata_i = '0;
    n_tests      = 0;
    n_checks     = 0;
    n_errors     = 0;
    err_base     = 0;
    void'($urandom(32'hd3d2_7358));
    repeat (5) @(negedge clk_core);
    reset_i = 1'b0;

    for (int i = 0; i < 20; i++) begin
      @(negedge clk_core);
      queue_result("idle instr_gnt", 1, '0, word_t'(instr_gnt_o));
      queue_result("idle data_gnt", 1, '0, word_t'(data_gnt_o));
      queue_result("idle data_rvalid", 1, '0, word_t'(data_rvalid_o));
    end
    end_test("idle after reset");

    for (int i = 0; i < N_PAIRS; i++) begin
      pair_addr[i] = word_addr($urandom_range(127));
      store_word($sformatf("write %0d", i), pair_addr[i], $urandom);
    end
    for (int i = 0; i < N_PAIRS; i++) begin
      load_word($sformatf("read %0d", i), pair_addr[i], lat);
    end
    end_test("data write and read");

    for (int i = 0; i < N_PAIRS; i++) begin
      instr_fetch($sformatf("fetch %0d", i), pair_addr[i], lat);
    end
    end_test("fetch of data writes");

    // Instruction region 512..575 stays fixed, data port owns 256..319
    for (int i = 0; i < 64; i++) begin
      store_word("preload instr", word_addr(512 + i), $urandom);
      store_word("preload data", word_addr(256 + i), $urandom);
    end
    fork
      begin : instr_stream
        int flat;
        for (int n = 0; n < N_RANDOM; n++) begin
          instr_fetch($sformatf("mixed fetch %0d", n), word_addr(512 + $urandom_range(63)), flat);
        end
      end
      begin : data_stream
        int unsigned didx;
        int          dlat;
        for (int n = 0; n < N_RANDOM; n++) begin
          didx = 256 + $urandom_range(63);
          if ($urandom_range(1) == 1) begin
            store_word($sformatf("mixed write %0d", n), word_addr(didx), $urandom);
          end else begin
            load_word($sformatf("mixed read %0d", n), word_addr(didx), dlat);
          end
        end
      end
    join
    end_test("concurrent ports");

    for (int i = 0; i < 4; i++) begin
      idx   = 128 + $urandom_range(63);
      addr  = word_addr(idx) | (addr_t'($urandom_range(1048575, 1)) << 12);  // High bits set
      wdata = $urandom;
      store_word($sformatf("alias write %0d", i), addr, wdata);
      load_word($sformatf("alias read %0d", i), word_addr(idx), lat);
    end
    end_test("address wrap");

    repeat (2) @(negedge clk_core);  // Both bridges back in IDLE
    load_word("latency read", pair_addr[0], lat);
    queue_result("data read latency", 2, word_t'(3), word_t'(lat));
    repeat (2) @(negedge clk_core);
    instr_fetch("latency fetch", pair_addr[0], lat);
    queue_result("fetch latency", 2, word_t'(3), word_t'(lat));
    end_test("uncontended latency");

    $display("Tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0 && !timed_out && !stuck) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: sources.f
common/mem_subsys_pkg.sv
core_bridge/instr_bridge.sv
core_bridge/data_bridge.sv
src/wb_arbiter.sv
src/wb_memory.sv
src/mem_subsys_top.sv
testbench/tb_mem_subsys.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the log holds the pass line
verilator --binary --timing --assert --top-module tb_mem_subsys -f sources.f \
  -o sim_mem_subsys > build.log 2>&1 || { cat build.log; echo "Build error"; exit 1; }
./obj_dir/sim_mem_subsys > sim.log 2>&1
cat sim.log
grep -q "^Verification passed$" sim.log && exit 0 || exit 1
